//--- common/trig_types_pkg.sv
package trig_types_pkg;

    // widest buffer address that fits in an output word
    localparam int MAX_ADDR_BITS = 12;

    // trigger word layout: flag on top, address from bit 2 up
    localparam int TRIG_FLAG_BIT = 15;
    localparam int ADDR_LSB = 2;

    // one source's trigger word
    typedef logic [15:0] trig_word_t;

    // address field of an output word
    typedef logic [MAX_ADDR_BITS-1:0] out_addr_t;

    // output stream word, tag 2'b10 + address + two pad bits
    typedef logic [15:0] trigout_word_t;

endpackage

//--- common/trig_ctrl_pkg.sv
package trig_ctrl_pkg;

    // width of each configuration field
    localparam int CFG_BITS = 16;

    // run sequencing
    typedef enum logic [1:0] {
        RUN_IDLE,
        RUN_LAT_WAIT,
        RUN_READOUT
    } run_state_t;

    // offset, latency or holdoff setting
    typedef logic [CFG_BITS-1:0] cfg_t;

    // latency parked at max while idle so readout never starts by accident
    localparam cfg_t LATENCY_IDLE = '1;

endpackage

//--- logic/trig_capture.sv
`timescale 1ns/1ps

module trig_capture #(
    parameter int NSRC      = 4,
    parameter int ADDR_BITS = 8
) (
    input  logic                                     sysclk_i,
    input  logic                                     runrst_i,
    input  trig_types_pkg::trig_word_t [NSRC-1:0]    trigin_dat_i,
    input  logic                                     trigin_valid_i,
    input  logic [NSRC-1:0]                          trigmask_i,
    input  logic                                     trigmask_update_i,
    input  logic                                     running_i,
    output logic [NSRC-1:0]                          wr_req_o,
    output logic [NSRC-1:0][ADDR_BITS-1:0]           wr_addr_o
);

    // set bit = source disabled
    logic [NSRC-1:0] trig_mask;
    // per-source trigger qualified by valid, flag, mask and run
    logic [NSRC-1:0] trig_hit;

    // mask update wins over reset so both can land on one edge
    always_ff @(posedge sysclk_i) begin
        if (trigmask_update_i) begin
            trig_mask <= trigmask_i;
        end else if (runrst_i) begin
            // everything masked until software says otherwise
            trig_mask <= '1;
        end
    end

    always_comb begin
        for (int s = 0; s < NSRC; s++) begin
            trig_hit[s] = trigin_valid_i
                        & trigin_dat_i[s][trig_types_pkg::TRIG_FLAG_BIT]
                        & ~trig_mask[s]
                        & running_i;
        end
    end

    // write request, one cycle after the word is sampled
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            wr_req_o <= '0;
        end else begin
            wr_req_o <= trig_hit;
        end
    end

    // address rides along with the request
    // bottom bits of the word are not part of the address
    always_ff @(posedge sysclk_i) begin
        for (int s = 0; s < NSRC; s++) begin
            wr_addr_o[s] <= trigin_dat_i[s][trig_types_pkg::ADDR_LSB +: ADDR_BITS];
        end
    end

endmodule

//--- logic/run_timer.sv
`timescale 1ns/1ps

module run_timer #(
    parameter int ADDR_BITS = 8
) (
    input  logic                   sysclk_i,
    input  logic                   runrst_i,
    input  logic                   runstop_i,
    input  trig_ctrl_pkg::cfg_t    trig_offset_i,
    input  trig_ctrl_pkg::cfg_t    trig_latency_i,
    input  trig_ctrl_pkg::cfg_t    trig_holdoff_i,
    output logic                   running_o,
    output logic                   readout_active_o,
    output logic [ADDR_BITS-1:0]   readout_addr_o,
    output logic [ADDR_BITS-1:0]   address_o,
    output trig_ctrl_pkg::cfg_t    offset_cfg_o,
    output trig_ctrl_pkg::cfg_t    holdoff_cfg_o
);

    trig_ctrl_pkg::run_state_t state;
    trig_ctrl_pkg::cfg_t       latency_cfg;
    // cycles spent in latency wait so far
    trig_ctrl_pkg::cfg_t       lat_cnt;
    // count value on the last latency-wait cycle
    trig_ctrl_pkg::cfg_t       lat_last;
    logic [ADDR_BITS-1:0]      cur_addr;
    logic [ADDR_BITS-1:0]      rd_addr;

    assign lat_last = latency_cfg - trig_ctrl_pkg::cfg_t'(1);

    // runrst beats runstop
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            // zero latency skips the wait entirely
            state <= (trig_latency_i == '0) ? trig_ctrl_pkg::RUN_READOUT
                                            : trig_ctrl_pkg::RUN_LAT_WAIT;
        end else if (runstop_i) begin
            state <= trig_ctrl_pkg::RUN_IDLE;
        end else if (state == trig_ctrl_pkg::RUN_LAT_WAIT && lat_cnt == lat_last) begin
            state <= trig_ctrl_pkg::RUN_READOUT;
        end
    end

    // settings captured at run start
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            offset_cfg_o  <= trig_offset_i;
            holdoff_cfg_o <= trig_holdoff_i;
            latency_cfg   <= trig_latency_i;
        end else if (runstop_i) begin
            latency_cfg   <= trig_ctrl_pkg::LATENCY_IDLE;
        end
    end

    // lat_cnt is 0 on the first running cycle
    always_ff @(posedge sysclk_i) begin
        if (runrst_i || state == trig_ctrl_pkg::RUN_IDLE) begin
            lat_cnt <= '0;
        end else if (state == trig_ctrl_pkg::RUN_LAT_WAIT) begin
            lat_cnt <= lat_cnt + trig_ctrl_pkg::cfg_t'(1);
        end
    end

    // current address, 0 on first running cycle, wraps naturally
    always_ff @(posedge sysclk_i) begin
        if (runrst_i || state == trig_ctrl_pkg::RUN_IDLE) begin
            cur_addr <= '0;
        end else begin
            cur_addr <= cur_addr + 1'b1;
        end
    end

    // readout address trails cur_addr by exactly the latency
    always_ff @(posedge sysclk_i) begin
        if (runrst_i || state != trig_ctrl_pkg::RUN_READOUT) begin
            rd_addr <= '0;
        end else begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    assign running_o        = (state != trig_ctrl_pkg::RUN_IDLE);
    assign readout_active_o = (state == trig_ctrl_pkg::RUN_READOUT);
    assign address_o        = cur_addr;
    assign readout_addr_o   = rd_addr;

endmodule

//--- logic/trig_delay_buffer.sv
`timescale 1ns/1ps

module trig_delay_buffer #(
    parameter int NSRC      = 4,
    parameter int ADDR_BITS = 8
) (
    input  logic                             sysclk_i,
    input  logic                             runrst_i,
    input  logic [NSRC-1:0]                  wr_req_i,
    input  logic [NSRC-1:0][ADDR_BITS-1:0]   wr_addr_i,
    input  logic                             readout_active_i,
    input  logic [ADDR_BITS-1:0]             readout_addr_i,
    output logic                             hit_o,
    output logic [ADDR_BITS-1:0]             hit_addr_o
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    // one flag per buffer address, per source
    logic [DEPTH-1:0] flag_mem [NSRC];
    // flags at the current readout address
    logic [NSRC-1:0]  rd_flags;

    always_comb begin
        for (int s = 0; s < NSRC; s++) begin
            rd_flags[s] = flag_mem[s][readout_addr_i];
        end
    end

    // whole buffer wipes at run start so old triggers never leak out
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            for (int s = 0; s < NSRC; s++) begin
                flag_mem[s] <= '0;
            end
        end else begin
            for (int s = 0; s < NSRC; s++) begin
                // read-and-clear at readout address
                if (readout_active_i) begin
                    flag_mem[s][readout_addr_i] <= 1'b0;
                end
                // later assignment, so a same-edge write beats the clear
                if (wr_req_i[s]) begin
                    flag_mem[s][wr_addr_i[s]] <= 1'b1;
                end
            end
        end
    end

    // any source flagged at this address is one hit
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            hit_o <= 1'b0;
        end else begin
            hit_o <= readout_active_i & (|rd_flags);
        end
    end

    always_ff @(posedge sysclk_i) begin
        hit_addr_o <= readout_addr_i;
    end

endmodule

//--- trig_output/trig_fifo.sv
`timescale 1ns/1ps

module trig_fifo #(
    parameter int FIFO_DEPTH = 4,
    parameter int WIDTH      = 16
) (
    input  logic               sysclk_i,
    input  logic               runrst_i,
    input  logic               flush_i,
    input  logic               wr_en_i,
    input  logic [WIDTH-1:0]   wr_data_i,
    output logic [WIDTH-1:0]   rd_data_o,
    output logic               rd_valid_o,
    input  logic               rd_ready_i
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // full means the new word is simply lost
    assign push = wr_en_i & (count != CNT_FULL);
    assign pop  = rd_valid_o & rd_ready_i;

    always_ff @(posedge sysclk_i) begin
        if (runrst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    // head word shown as soon as it lands
    assign rd_data_o  = mem[rd_ptr];
    // flush hides stale words during the cycle they are dropped
    assign rd_valid_o = (count != '0) & ~flush_i;

endmodule

//--- trig_output/trig_output.sv
`timescale 1ns/1ps

module trig_output #(
    parameter int ADDR_BITS  = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                            sysclk_i,
    input  logic                            runrst_i,
    input  logic                            running_i,
    input  logic                            hit_i,
    input  logic [ADDR_BITS-1:0]            hit_addr_i,
    input  trig_ctrl_pkg::cfg_t             offset_cfg_i,
    input  trig_ctrl_pkg::cfg_t             holdoff_cfg_i,
    output trig_types_pkg::trigout_word_t   trigout_tdata_o,
    output logic                            trigout_tvalid_o,
    input  logic                            trigout_tready_i
);

    localparam int WORD_BITS = $bits(trig_types_pkg::trigout_word_t);

    // hits still to be swallowed after the last accepted one
    trig_ctrl_pkg::cfg_t             hold_cnt;
    logic                            accept;
    logic [ADDR_BITS-1:0]            rel_addr;
    trig_types_pkg::out_addr_t       word_addr;
    trig_types_pkg::trigout_word_t   word_d;
    logic                            fifo_wr_en;
    trig_types_pkg::trigout_word_t   fifo_wr_data;
    logic                            fifo_flush;

    assign accept = hit_i & running_i & (hold_cnt == '0);

    // offset wraps within the buffer range
    assign rel_addr = hit_addr_i - offset_cfg_i[ADDR_BITS-1:0];

    // zero-extend into the 12-bit address field
    always_comb begin
        word_addr = '0;
        word_addr[ADDR_BITS-1:0] = rel_addr;
    end

    // tag 10, address, zero pad below
    assign word_d = {2'b10, word_addr, {trig_types_pkg::ADDR_LSB{1'b0}}};

    // holdoff H drops the next H readout addresses
    always_ff @(posedge sysclk_i) begin
        if (runrst_i || !running_i) begin
            hold_cnt <= '0;
        end else if (accept) begin
            hold_cnt <= holdoff_cfg_i;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - trig_ctrl_pkg::cfg_t'(1);
        end
    end

    // FIFO write one cycle after the hit
    always_ff @(posedge sysclk_i) begin
        if (runrst_i) begin
            fifo_wr_en <= 1'b0;
        end else begin
            fifo_wr_en <= accept;
        end
    end

    always_ff @(posedge sysclk_i) begin
        fifo_wr_data <= word_d;
    end

    // nothing pending survives a stop
    assign fifo_flush = ~running_i;

    trig_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .WIDTH      (WORD_BITS)
    ) trig_fifo_inst (
        .sysclk_i   (sysclk_i),
        .runrst_i   (runrst_i),
        .flush_i    (fifo_flush),
        .wr_en_i    (fifo_wr_en),
        .wr_data_i  (fifo_wr_data),
        .rd_data_o  (trigout_tdata_o),
        .rd_valid_o (trigout_tvalid_o),
        .rd_ready_i (trigout_tready_i)
    );

endmodule

//--- logic/master_trig_top.sv
`timescale 1ns/1ps

module master_trig_top #(
    parameter int NSRC       = 4,
    parameter int ADDR_BITS  = 8,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                   sysclk_i,
    input  logic                                   runrst_i,
    input  logic                                   runstop_i,
    input  trig_types_pkg::trig_word_t [NSRC-1:0]  trigin_dat_i,
    input  logic                                   trigin_valid_i,
    input  logic [NSRC-1:0]                        trigmask_i,
    input  logic                                   trigmask_update_i,
    input  trig_ctrl_pkg::cfg_t                    trig_offset_i,
    input  trig_ctrl_pkg::cfg_t                    trig_latency_i,
    input  trig_ctrl_pkg::cfg_t                    trig_holdoff_i,
    output logic                                   running_o,
    output logic [ADDR_BITS-1:0]                   address_o,
    output trig_types_pkg::trigout_word_t          trigout_tdata_o,
    output logic                                   trigout_tvalid_o,
    input  logic                                   trigout_tready_i
);

    // run control fan-out
    logic                            running;
    logic                            readout_active;
    logic [ADDR_BITS-1:0]            readout_addr;
    trig_ctrl_pkg::cfg_t             offset_cfg;
    trig_ctrl_pkg::cfg_t             holdoff_cfg;
    // capture into buffer
    logic [NSRC-1:0]                 wr_req;
    logic [NSRC-1:0][ADDR_BITS-1:0]  wr_addr;
    // buffer readout
    logic                            hit;
    logic [ADDR_BITS-1:0]            hit_addr;

    trig_capture #(
        .NSRC      (NSRC),
        .ADDR_BITS (ADDR_BITS)
    ) trig_capture_inst (
        .sysclk_i          (sysclk_i),
        .runrst_i          (runrst_i),
        .trigin_dat_i      (trigin_dat_i),
        .trigin_valid_i    (trigin_valid_i),
        .trigmask_i        (trigmask_i),
        .trigmask_update_i (trigmask_update_i),
        .running_i         (running),
        .wr_req_o          (wr_req),
        .wr_addr_o         (wr_addr)
    );

    run_timer #(
        .ADDR_BITS (ADDR_BITS)
    ) run_timer_inst (
        .sysclk_i         (sysclk_i),
        .runrst_i         (runrst_i),
        .runstop_i        (runstop_i),
        .trig_offset_i    (trig_offset_i),
        .trig_latency_i   (trig_latency_i),
        .trig_holdoff_i   (trig_holdoff_i),
        .running_o        (running),
        .readout_active_o (readout_active),
        .readout_addr_o   (readout_addr),
        .address_o        (address_o),
        .offset_cfg_o     (offset_cfg),
        .holdoff_cfg_o    (holdoff_cfg)
    );

    trig_delay_buffer #(
        .NSRC      (NSRC),
        .ADDR_BITS (ADDR_BITS)
    ) trig_delay_buffer_inst (
        .sysclk_i         (sysclk_i),
        .runrst_i         (runrst_i),
        .wr_req_i         (wr_req),
        .wr_addr_i        (wr_addr),
        .readout_active_i (readout_active),
        .readout_addr_i   (readout_addr),
        .hit_o            (hit),
        .hit_addr_o       (hit_addr)
    );

    trig_output #(
        .ADDR_BITS  (ADDR_BITS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) trig_output_inst (
        .sysclk_i         (sysclk_i),
        .runrst_i         (runrst_i),
        .running_i        (running),
        .hit_i            (hit),
        .hit_addr_i       (hit_addr),
        .offset_cfg_i     (offset_cfg),
        .holdoff_cfg_i    (holdoff_cfg),
        .trigout_tdata_o  (trigout_tdata_o),
        .trigout_tvalid_o (trigout_tvalid_o),
        .trigout_tready_i (trigout_tready_i)
    );

    assign running_o = running;

endmodule

//--- tb/master_trig_asserts.sv
`timescale 1ns/1ps

module master_trig_asserts #(
    parameter int ADDR_BITS = 8
) (
    input logic                          sysclk_i,
    input logic                          runrst_i,
    input logic                          runstop_i,
    input logic                          running_i,
    input logic [ADDR_BITS-1:0]          address_i,
    input trig_types_pkg::trigout_word_t tdata_i,
    input logic                          tvalid_i,
    input logic                          tready_i
);

    // checks only make sense once the first run reset has gone by
    logic armed;
    // number of assertion failures so far
    int fail_count = 0;

    initial armed = 1'b0;

    always @(posedge sysclk_i) begin
        if (runrst_i) begin
            armed <= 1'b1;
        end
    end

    // run starts one cycle after runrst
    run_start_a: assert property (@(posedge sysclk_i) disable iff (!armed)
        runrst_i |=> running_i)
        else begin
            $error("running_o did not rise after runrst_i");
            fail_count++;
        end

    // stop takes one cycle and runrst wins if both are present
    run_stop_a: assert property (@(posedge sysclk_i) disable iff (!armed)
        (runstop_i && !runrst_i) |=> !running_i)
        else begin
            $error("running_o did not fall after runstop_i");
            fail_count++;
        end

    // current address steps by one and wraps at the buffer size
    addr_step_a: assert property (@(posedge sysclk_i) disable iff (!armed)
        (running_i && !runrst_i && !runstop_i)
            |=> (address_i == ADDR_BITS'($past(address_i) + ADDR_BITS'(1))))
        else begin
            $error("address_o did not increment while running");
            fail_count++;
        end

    // stalled word must not move
    stall_hold_a: assert property (@(posedge sysclk_i) disable iff (!armed)
        (tvalid_i && !tready_i && !runrst_i && !runstop_i)
            |=> (tvalid_i && $stable(tdata_i)))
        else begin
            $error("trigout_tdata_o changed while stalled");
            fail_count++;
        end

    // stream is quiet outside a run
    idle_quiet_a: assert property (@(posedge sysclk_i) disable iff (!armed)
        !running_i |-> !tvalid_i)
        else begin
            $error("trigout_tvalid_o high while not running");
            fail_count++;
        end

endmodule

bind master_trig_top master_trig_asserts #(
    .ADDR_BITS (ADDR_BITS)
) master_trig_asserts_inst (
    .sysclk_i  (sysclk_i),
    .runrst_i  (runrst_i),
    .runstop_i (runstop_i),
    .running_i (running_o),
    .address_i (address_o),
    .tdata_i   (trigout_tdata_o),
    .tvalid_i  (trigout_tvalid_o),
    .tready_i  (trigout_tready_i)
);

//--- tb/tb_master_trig.sv
`timescale 1ns/1ps

module tb_master_trig;

    localparam int NSRC           = 4;
    localparam int ADDR_BITS      = 8;
    localparam int FIFO_DEPTH     = 4;
    // six tests stay near 2000 cycles even at latency 64
    localparam int TIMEOUT_CYCLES = 4000;
    // longest single wait is a full trip round the buffer plus slack
    localparam int WAIT_LIMIT     = 400;

    logic                                   sysclk_i;
    logic                                   runrst_i;
    logic                                   runstop_i;
    trig_types_pkg::trig_word_t [NSRC-1:0]  trigin_dat_i;
    logic                                   trigin_valid_i;
    logic [NSRC-1:0]                        trigmask_i;
    logic                                   trigmask_update_i;
    trig_ctrl_pkg::cfg_t                    trig_offset_i;
    trig_ctrl_pkg::cfg_t                    trig_latency_i;
    trig_ctrl_pkg::cfg_t                    trig_holdoff_i;
    logic                                   running_o;
    logic [ADDR_BITS-1:0]                   address_o;
    trig_types_pkg::trigout_word_t          trigout_tdata_o;
    logic                                   trigout_tvalid_o;
    logic                                   trigout_tready_i;

    // words still owed by the stream, oldest first
    trig_types_pkg::trigout_word_t exp_q[$];
    // settings of the run in progress
    trig_ctrl_pkg::cfg_t cur_offset;
    trig_ctrl_pkg::cfg_t cur_latency;
    int error_count;
    int tests_run;
    int tests_failed;
    int errors_at_test_start;
    int cycle_count = 0;

    master_trig_top #(
        .NSRC       (NSRC),
        .ADDR_BITS  (ADDR_BITS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) master_trig_top_inst (
        .sysclk_i          (sysclk_i),
        .runrst_i          (runrst_i),
        .runstop_i         (runstop_i),
        .trigin_dat_i      (trigin_dat_i),
        .trigin_valid_i    (trigin_valid_i),
        .trigmask_i        (trigmask_i),
        .trigmask_update_i (trigmask_update_i),
        .trig_offset_i     (trig_offset_i),
        .trig_latency_i    (trig_latency_i),
        .trig_holdoff_i    (trig_holdoff_i),
        .running_o         (running_o),
        .address_o         (address_o),
        .trigout_tdata_o   (trigout_tdata_o),
        .trigout_tvalid_o  (trigout_tvalid_o),
        .trigout_tready_i  (trigout_tready_i)
    );

    initial sysclk_i = 1'b0;

    always #4 sysclk_i = ~sysclk_i;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED %s expected 0x%0h got 0x%0h", name, expected, actual);
            error_count++;
        end
    endtask

    // testbench errors plus failures of the bound assertions
    function automatic int total_errors();
        return error_count + master_trig_top_inst.master_trig_asserts_inst.fail_count;
    endfunction

    // every transfer is matched against the oldest expected word
    always @(posedge sysclk_i) begin
        if (trigout_tvalid_o && trigout_tready_i) begin
            if (exp_q.size() == 0) begin
                $display("unexpected trigger word 0x%04h arrived", trigout_tdata_o);
                error_count++;
            end else begin
                check_value("trigout_tdata_o", exp_q[0], trigout_tdata_o);
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge sysclk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // inputs move 1 ns after the edge
    task automatic tick(input int n);
        repeat (n) @(posedge sysclk_i);
        #1;
    endtask

    task automatic start_run(input trig_ctrl_pkg::cfg_t off, input trig_ctrl_pkg::cfg_t lat,
                             input trig_ctrl_pkg::cfg_t hold, input int cycles);
        trig_offset_i  = off;
        trig_latency_i = lat;
        trig_holdoff_i = hold;
        runrst_i       = 1'b1;
        tick(cycles);
        runrst_i       = 1'b0;
        cur_offset     = off;
        cur_latency    = lat;
    endtask

    // set bit disables the source
    task automatic set_mask(input logic [NSRC-1:0] m);
        trigmask_i        = m;
        trigmask_update_i = 1'b1;
        tick(1);
        trigmask_update_i = 1'b0;
    endtask

    // readout trails the current address by the latency
    function automatic logic [ADDR_BITS-1:0] readout_pos();
        return address_o - cur_latency[ADDR_BITS-1:0];
    endfunction

    // pick an address the readout reaches in margin to margin+7 cycles
    function automatic logic [ADDR_BITS-1:0] aim(input int margin);
        return ADDR_BITS'(int'(readout_pos()) + margin + int'($urandom % 8));
    endfunction

    // tag 10, (A - offset) mod buffer size in 12 bits, two zero bits
    function automatic trig_types_pkg::trigout_word_t expected_word(
            input logic [ADDR_BITS-1:0] a);
        int rel;
        trig_types_pkg::trigout_word_t w;
        rel = (int'(a) - int'(cur_offset)) % (1 << ADDR_BITS);
        if (rel < 0) begin
            rel += (1 << ADDR_BITS);
        end
        w = '0;
        w[15:14] = 2'b10;
        w[13:2]  = 12'(rel);
        return w;
    endfunction

    task automatic fire(input logic [NSRC-1:0] srcs, input logic [ADDR_BITS-1:0] a);
        trig_types_pkg::trig_word_t w;
        w = '0;
        w[trig_types_pkg::TRIG_FLAG_BIT] = 1'b1;
        w[trig_types_pkg::ADDR_LSB +: ADDR_BITS] = a;
        for (int s = 0; s < NSRC; s++) begin
            trigin_dat_i[s] = srcs[s] ? w : '0;
        end
        trigin_valid_i = 1'b1;
        tick(1);
        trigin_valid_i = 1'b0;
        trigin_dat_i   = '0;
    endtask

    // first readout cycle is when address_o equals the latency
    task automatic wait_readout();
        int n;
        n = 0;
        while (address_o != cur_latency[ADDR_BITS-1:0] && n < WAIT_LIMIT) begin
            tick(1);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("readout never started");
            error_count++;
        end
    endtask

    // a word for address a is out 3 cycles after readout reaches it
    task automatic wait_past(input logic [ADDR_BITS-1:0] a);
        logic [ADDR_BITS-1:0] target;
        int n;
        target = a + ADDR_BITS'(6);
        n = 0;
        while (readout_pos() != target && n < WAIT_LIMIT) begin
            tick(1);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("readout never passed address 0x%02h", a);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            tick(1);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("expected trigger word 0x%04h never arrived", exp_q[0]);
            error_count++;
            exp_q.delete();
        end
        tests_run++;
        if (total_errors() == errors_at_test_start) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, total_errors() - errors_at_test_start);
        end
        errors_at_test_start = total_errors();
    endtask

    initial begin
        logic [ADDR_BITS-1:0] a;
        logic [ADDR_BITS-1:0] a2;
        int s1;
        int s2;
        void'($urandom(32'hef7e));
        runrst_i          = 1'b0;
        runstop_i         = 1'b0;
        trigin_dat_i      = '0;
        trigin_valid_i    = 1'b0;
        trigmask_i        = '1;
        trigmask_update_i = 1'b0;
        trig_offset_i     = '0;
        trig_latency_i    = '0;
        trig_holdoff_i    = '0;
        trigout_tready_i  = 1'b1;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        errors_at_test_start = 0;
        #1;

        // reset held two cycles also starts the first run
        start_run(16'd5, 16'd32, 16'd0, 2);
        check_value("running_o", 32'h1, running_o);
        check_value("address_o", 32'h0, address_o);
        tick(1);
        check_value("address_o", 32'h1, address_o);
        set_mask(4'b1110);
        wait_readout();
        // this one sits in the FIFO behind a stalled stream when the run stops
        trigout_tready_i = 1'b0;
        a = aim(20);
        fire(4'b0001, a);
        wait_past(a);
        // this one is still in the buffer when the run stops
        fire(4'b0001, aim(20));
        tick(2);
        runstop_i = 1'b1;
        tick(1);
        runstop_i = 1'b0;
        check_value("running_o", 32'h0, running_o);
        trigout_tready_i = 1'b1;
        fire(4'b0001, ADDR_BITS'($urandom));
        tick(40);
        check_value("running_o", 32'h0, running_o);
        end_test("run_control");

        // basic path with an offset larger than the address so it wraps
        start_run(16'd200, 16'd40, 16'd0, 1);
        set_mask(4'b0000);
        wait_readout();
        s1 = int'($urandom % NSRC);
        a = aim(20);
        exp_q.push_back(expected_word(a));
        fire(NSRC'(1) << s1, a);
        wait_past(a);
        // two sources on one address give a single word
        s2 = (s1 + 1 + int'($urandom % (NSRC - 1))) % NSRC;
        a = aim(20);
        exp_q.push_back(expected_word(a));
        fire((NSRC'(1) << s1) | (NSRC'(1) << s2), a);
        wait_past(a);
        end_test("basic_path");

        // masking
        set_mask(4'b0010);
        a = aim(20);
        fire(4'b0010, a);
        wait_past(a);
        set_mask(4'b0000);
        a = aim(20);
        exp_q.push_back(expected_word(a));
        fire(4'b0010, a);
        wait_past(a);
        end_test("masking");

        // holdoff of 10 readout addresses
        start_run(16'd3, 16'd24, 16'd10, 1);
        set_mask(4'b0000);
        wait_readout();
        a = aim(20);
        exp_q.push_back(expected_word(a));
        fire(NSRC'(1) << ($urandom % NSRC), a);
        fire(NSRC'(1) << ($urandom % NSRC), a + ADDR_BITS'(2));
        wait_past(a + ADDR_BITS'(2));
        a = aim(20);
        a2 = a + ADDR_BITS'(15);
        exp_q.push_back(expected_word(a));
        exp_q.push_back(expected_word(a2));
        fire(NSRC'(1) << ($urandom % NSRC), a);
        fire(NSRC'(1) << ($urandom % NSRC), a2);
        wait_past(a2);
        end_test("holdoff");

        // back-pressure with three words parked in the FIFO
        start_run(16'd9, 16'd16, 16'd0, 1);
        set_mask(4'b0000);
        wait_readout();
        trigout_tready_i = 1'b0;
        a = aim(20);
        for (int k = 0; k < 3; k++) begin
            exp_q.push_back(expected_word(a + ADDR_BITS'(3 * k)));
            fire(NSRC'(1) << ($urandom % NSRC), a + ADDR_BITS'(3 * k));
        end
        wait_past(a + ADDR_BITS'(6));
        tick(4);
        trigout_tready_i = 1'b1;
        end_test("back_pressure");

        // restart drops a stalled word and an unread buffer entry
        trigout_tready_i = 1'b0;
        a = aim(20);
        a2 = a + ADDR_BITS'(30);
        fire(NSRC'(1) << ($urandom % NSRC), a);
        fire(NSRC'(1) << ($urandom % NSRC), a2);
        wait_past(a);
        start_run(16'd50, 16'd48, 16'd0, 1);
        trigout_tready_i = 1'b1;
        set_mask(4'b0000);
        wait_readout();
        a = aim(20);
        exp_q.push_back(expected_word(a));
        fire(NSRC'(1) << ($urandom % NSRC), a);
        wait_past(a);
        wait_past(a2);
        end_test("restart");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- files.f
common/trig_types_pkg.sv
common/trig_ctrl_pkg.sv
logic/trig_capture.sv
logic/run_timer.sv
logic/trig_delay_buffer.sv
trig_output/trig_fifo.sv
trig_output/trig_output.sv
logic/master_trig_top.sv
tb/master_trig_asserts.sv
tb/tb_master_trig.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the master trigger testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_master_trig
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_master_trig \
    -f files.f \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG_FILE"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
